//--- hdl/i8008_pkg.sv
`default_nettype none

package i8008_pkg;

  typedef logic [7:0]  data_t;    // Data and bus byte
  typedef logic [13:0] addr_t;    // 16K address space
  typedef logic [2:0]  reg_sel_t; // Scratchpad index, 7 is memory

  typedef enum logic [2:0] {
    T1,
    T2,
    WAIT,
    T3,
    T4,
    T5,
    STOPPED
  } state_t;

  typedef enum logic [1:0] {
    CYCLE1,
    CYCLE2
  } mcycle_t;

  // Cycle type bits sent in T2
  typedef enum logic [1:0] {
    PCI = 2'b00,
    PCR = 2'b01,
    PCW = 2'b11
  } cycle_type_t;

  typedef enum logic [2:0] {ADD, ADC, SUB, SBB, ANA, XRA, ORA, CMP} alu_op_t;
  typedef enum logic [1:0] {RLC, RRC, RAL, RAR} rot_op_t;
  typedef enum logic [1:0] {ALU_LOGIC, ALU_ROT, ALU_INC, ALU_DEC} alu_mode_t;

  typedef enum logic [2:0] {
    BUS_NONE, BUS_PC_LO, BUS_PC_HI, BUS_RF, BUS_ALU, BUS_TMP_A, BUS_TMP_B, BUS_DIN
  } bus_src_t;

  localparam reg_sel_t REG_A = 3'd0;
  localparam reg_sel_t REG_H = 3'd5;
  localparam reg_sel_t REG_L = 3'd6;
  localparam reg_sel_t REG_M = 3'd7;

  // Opcode fields: GG DDD SSS
  localparam int unsigned GRP_HI = 7;
  localparam int unsigned GRP_LO = 6;
  localparam int unsigned DDD_HI = 5;
  localparam int unsigned DDD_LO = 3;
  localparam int unsigned SSS_HI = 2;
  localparam int unsigned SSS_LO = 0;

  localparam logic [1:0] GRP_IMM = 2'b00; // INr, DCr, rotates, LrI, HLT
  localparam logic [1:0] GRP_ALU = 2'b10;
  localparam logic [1:0] GRP_MOV = 2'b11;

  localparam logic [2:0] SSS_INR = 3'b000;
  localparam logic [2:0] SSS_DCR = 3'b001;
  localparam logic [2:0] SSS_ROT = 3'b010;
  localparam logic [2:0] SSS_LRI = 3'b110;
  localparam data_t      OP_HLT  = 8'hff; // Also 0000000x

endpackage

`default_nettype wire

//--- hdl/i8008_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface i8008_ctrl_if
  import i8008_pkg::*;
();

  bus_src_t    bus_src;
  reg_sel_t    rf_sel;
  logic        rf_we;
  logic        tmp_a_we;
  logic        tmp_b_we;
  alu_mode_t   alu_mode;
  alu_op_t     alu_op;
  rot_op_t     rot_op;
  logic        carry_we;
  logic        ir_we;
  logic        pc_inc;
  cycle_type_t cycle_type;
  data_t       instr; // Current opcode, bypassed during fetch

  modport ctrl (
    output bus_src, rf_sel, rf_we, tmp_a_we, tmp_b_we, alu_mode, alu_op, rot_op,
    output carry_we, ir_we, pc_inc, cycle_type,
    input  instr
  );

  modport dp (
    input  bus_src, rf_sel, rf_we, tmp_a_we, tmp_b_we, alu_mode, alu_op, rot_op,
    input  carry_we, ir_we, pc_inc, cycle_type,
    output instr
  );

endinterface

`default_nettype wire

//--- hdl/i8008_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module i8008_reg_file
  import i8008_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  reg_sel_t sel,
  input  logic     we,
  input  data_t    wdata,
  output data_t    rdata
);

  data_t regs [0:6]; // A B C D E H L

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 7; i++) begin
        regs[i] <= 8'h00;
      end
    end else if (we && sel != REG_M) begin
      regs[sel] <= wdata;
    end
  end

  // M has no storage here
  assign rdata = (sel == REG_M) ? 8'h00 : regs[sel];

endmodule

`default_nettype wire

//--- hdl/i8008_alu.sv
`timescale 1ns/1ps
`default_nettype none

module i8008_alu
  import i8008_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  data_t     a,
  input  data_t     b,
  input  alu_mode_t mode,
  input  alu_op_t   op,
  input  rot_op_t   rot,
  input  logic      carry_we,
  output data_t     result
);

  logic       carry;
  logic       carry_next;
  logic [8:0] wide; // Bit 8 is carry out or borrow

  always_comb begin
    wide       = 9'd0;
    carry_next = carry;
    case (mode)
      ALU_LOGIC: begin
        case (op)
          ADD:     wide = {1'b0, a} + {1'b0, b};
          ADC:     wide = {1'b0, a} + {1'b0, b} + {8'd0, carry};
          SUB:     wide = {1'b0, a} - {1'b0, b};
          SBB:     wide = {1'b0, a} - {1'b0, b} - {8'd0, carry};
          ANA:     wide = {1'b0, a & b};
          XRA:     wide = {1'b0, a ^ b};
          ORA:     wide = {1'b0, a | b};
          default: wide = {1'b0, a} - {1'b0, b}; // CMP
        endcase
        carry_next = wide[8]; // Logic ops leave bit 8 clear
      end
      ALU_ROT: begin
        case (rot)
          RLC:     wide = {a[7], a[6:0], a[7]};
          RRC:     wide = {a[0], a[0], a[7:1]};
          RAL:     wide = {a[7], a[6:0], carry};
          default: wide = {a[0], carry, a[7:1]}; // RAR
        endcase
        carry_next = wide[8];
      end
      ALU_INC: wide = {1'b0, a + 8'd1};
      default: wide = {1'b0, a - 8'd1};
    endcase
  end

  assign result = wide[7:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      carry <= 1'b0;
    end else if (carry_we) begin
      carry <= carry_next;
    end
  end

endmodule

`default_nettype wire

//--- hdl/i8008_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module i8008_datapath
  import i8008_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  data_t    d_in,
  output data_t    d_out,
  i8008_ctrl_if.dp bus
);

  data_t      ibus;
  data_t      ir;
  data_t      tmp_a;
  data_t      tmp_b;
  data_t      rf_rdata;
  data_t      alu_a;
  data_t      alu_result;
  addr_t      pc;
  logic [5:0] hi_addr;

  // Memory writes take H, fetches and immediates the PC
  assign hi_addr = (bus.cycle_type == PCW) ? rf_rdata[5:0] : pc[13:8];

  always_comb begin
    case (bus.bus_src)
      BUS_PC_LO: ibus = pc[7:0];
      BUS_PC_HI: ibus = {bus.cycle_type, hi_addr};
      BUS_RF:    ibus = rf_rdata;
      BUS_ALU:   ibus = alu_result;
      BUS_TMP_A: ibus = tmp_a;
      BUS_TMP_B: ibus = tmp_b;
      BUS_DIN:   ibus = d_in;
      default:   ibus = 8'h00;
    endcase
  end

  assign d_out = ibus;

  // Decode sees the opcode during its own fetch T3
  assign bus.instr = bus.ir_we ? d_in : ir;

  // Accumulator feeds the ALU directly for register operations
  assign alu_a = (bus.alu_mode == ALU_LOGIC) ? rf_rdata : tmp_a;

  always_ff @(posedge clk) begin
    if (rst) begin
      ir    <= 8'h00;
      tmp_a <= 8'h00;
      tmp_b <= 8'h00;
      pc    <= '0;
    end else begin
      if (bus.ir_we) begin
        ir <= d_in;
      end
      if (bus.tmp_a_we) begin
        tmp_a <= ibus;
      end
      if (bus.tmp_b_we) begin
        tmp_b <= ibus;
      end
      if (bus.pc_inc) begin
        pc <= pc + 14'd1; // Wraps at 16K
      end
    end
  end

  i8008_reg_file rf (
    .clk   (clk),
    .rst   (rst),
    .sel   (bus.rf_sel),
    .we    (bus.rf_we),
    .wdata (ibus),
    .rdata (rf_rdata)
  );

  i8008_alu alu (
    .clk      (clk),
    .rst      (rst),
    .a        (alu_a),
    .b        (tmp_b),
    .mode     (bus.alu_mode),
    .op       (bus.alu_op),
    .rot      (bus.rot_op),
    .carry_we (bus.carry_we),
    .result   (alu_result)
  );

  a_no_mem_write: assert property (@(posedge clk) disable iff (rst)
    !(bus.rf_we && bus.rf_sel == REG_M))
    else $error("register write with M selected");

endmodule

`default_nettype wire

//--- hdl/i8008_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module i8008_ctrl
  import i8008_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       ready,
  output state_t     state,
  i8008_ctrl_if.ctrl bus
);

  mcycle_t  mcycle;
  mcycle_t  next_mcycle;
  state_t   next_state;
  data_t    instr;
  reg_sel_t ddd;
  reg_sel_t sss;
  logic     is_hlt, is_mov, is_lmr, is_lri, is_inr, is_dcr, is_rot, is_alu;

  assign instr = bus.instr;
  assign ddd   = instr[DDD_HI:DDD_LO];
  assign sss   = instr[SSS_HI:SSS_LO];

  // Kept instruction set, anything else runs as a no-op
  assign is_hlt = (instr[7:1] == 7'd0) || (instr == OP_HLT);
  assign is_mov = (instr[GRP_HI:GRP_LO] == GRP_MOV) && (ddd != REG_M) && (sss != REG_M);
  assign is_lmr = (instr[GRP_HI:GRP_LO] == GRP_MOV) && (ddd == REG_M) && (sss != REG_M);
  assign is_lri = (instr[GRP_HI:GRP_LO] == GRP_IMM) && (sss == SSS_LRI) && (ddd != REG_M);
  assign is_inr = (instr[GRP_HI:GRP_LO] == GRP_IMM) && (sss == SSS_INR) &&
                  (ddd != REG_A) && (ddd != REG_M);
  assign is_dcr = (instr[GRP_HI:GRP_LO] == GRP_IMM) && (sss == SSS_DCR) &&
                  (ddd != REG_A) && (ddd != REG_M);
  assign is_rot = (instr[GRP_HI:GRP_LO] == GRP_IMM) && (sss == SSS_ROT) && !ddd[2];
  assign is_alu = (instr[GRP_HI:GRP_LO] == GRP_ALU) && (sss != REG_M);

  // IR loads at the end of every fetch T3
  assign bus.ir_we = (state == T3) && (mcycle == CYCLE1);

  always_comb begin
    next_state  = state;
    next_mcycle = mcycle;
    case (state)
      T1:      next_state = T2;
      T2:      next_state = ready ? T3 : WAIT;
      WAIT:    next_state = ready ? T3 : WAIT;
      T3: begin
        if (mcycle == CYCLE1) begin
          if (is_hlt) begin
            next_state = STOPPED;
          end else if (is_lri) begin
            next_state  = T1;
            next_mcycle = CYCLE2;
          end else begin
            next_state = T4;
          end
        end else if (is_lmr) begin
          next_state  = T1; // Store done
          next_mcycle = CYCLE1;
        end else begin
          next_state = T4;
        end
      end
      T4: begin
        if (mcycle == CYCLE1 && is_lmr) begin
          next_state  = T1;
          next_mcycle = CYCLE2;
        end else begin
          next_state = T5;
        end
      end
      T5: begin
        next_state  = T1;
        next_mcycle = CYCLE1;
      end
      STOPPED: next_state = STOPPED; // Only rst leaves
      default: begin
        next_state  = T1;
        next_mcycle = CYCLE1;
      end
    endcase
  end

  always_comb begin
    bus.bus_src    = BUS_NONE;
    bus.rf_sel     = REG_A;
    bus.rf_we      = 1'b0;
    bus.tmp_a_we   = 1'b0;
    bus.tmp_b_we   = 1'b0;
    bus.alu_mode   = ALU_LOGIC;
    bus.alu_op     = alu_op_t'(ddd);
    bus.rot_op     = rot_op_t'(ddd[1:0]);
    bus.carry_we   = 1'b0;
    bus.pc_inc     = 1'b0;
    bus.cycle_type = (mcycle == CYCLE2) ? (is_lmr ? PCW : PCR) : PCI;
    case (state)
      T1: begin
        if (bus.cycle_type == PCW) begin
          bus.bus_src = BUS_RF; // L is the low address
          bus.rf_sel  = REG_L;
        end else begin
          bus.bus_src = BUS_PC_LO;
        end
      end
      T2: begin
        bus.bus_src = BUS_PC_HI;
        bus.rf_sel  = REG_H;
        bus.pc_inc  = (bus.cycle_type != PCW);
      end
      T3: begin
        if (bus.cycle_type == PCW) begin
          bus.bus_src = BUS_TMP_B;
        end else begin
          bus.bus_src  = BUS_DIN;
          bus.tmp_b_we = (mcycle == CYCLE2); // Immediate byte
        end
      end
      T4: begin
        if (mcycle == CYCLE1) begin
          bus.bus_src = BUS_RF;
          if (is_mov || is_alu || is_lmr) begin
            bus.rf_sel   = sss;
            bus.tmp_b_we = 1'b1;
          end else if (is_inr || is_dcr) begin
            bus.rf_sel   = ddd;
            bus.tmp_a_we = 1'b1;
          end else if (is_rot) begin
            bus.tmp_a_we = 1'b1;
          end
        end
      end
      T5: begin
        if (mcycle == CYCLE2 || is_mov) begin
          bus.bus_src = BUS_TMP_B;
          bus.rf_sel  = ddd;
          bus.rf_we   = 1'b1;
        end else if (is_alu) begin
          bus.bus_src  = BUS_ALU;
          bus.rf_we    = (bus.alu_op != CMP);
          bus.carry_we = 1'b1;
        end else if (is_rot) begin
          bus.bus_src  = BUS_ALU;
          bus.alu_mode = ALU_ROT;
          bus.rf_we    = 1'b1;
          bus.carry_we = 1'b1;
        end else if (is_inr || is_dcr) begin
          bus.bus_src  = BUS_ALU;
          bus.alu_mode = is_inr ? ALU_INC : ALU_DEC;
          bus.rf_sel   = ddd;
          bus.rf_we    = 1'b1;
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= T1;
      mcycle <= CYCLE1;
    end else begin
      state  <= next_state;
      mcycle <= next_mcycle;
    end
  end

  a_halt_sticky: assert property (@(posedge clk) (state == STOPPED && !rst) |=> state == STOPPED)
    else $error("core left STOPPED without reset");

endmodule

`default_nettype wire

//--- hdl/i8008_top.sv
`timescale 1ns/1ps
`default_nettype none

module i8008_top
  import i8008_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  data_t  d_in,
  input  logic   ready,
  output data_t  d_out,
  output state_t state
);

  i8008_ctrl_if ctrl_bus ();

  i8008_ctrl ctrl (
    .clk   (clk),
    .rst   (rst),
    .ready (ready), // Plain level, sampled in T2 and WAIT
    .state (state),
    .bus   (ctrl_bus)
  );

  i8008_datapath dp (
    .clk   (clk),
    .rst   (rst),
    .d_in  (d_in),
    .d_out (d_out),
    .bus   (ctrl_bus)
  );

endmodule

`default_nettype wire

//--- sim/i8008_tb.sv
`timescale 1ns/1ps
`default_nettype none

module i8008_tb
  import i8008_pkg::*;
();

  logic        clk = 1'b0;
  logic        rst;
  logic        ready;
  data_t       d_in;
  data_t       d_out;
  state_t      state;

  data_t       mem [0:16383];
  logic [31:0] lfsr = 32'hae68;
  data_t       model_regs [0:6];
  logic        model_c;
  addr_t       gen_pc;   // Next program byte
  addr_t       next_pc;  // Next expected read address
  addr_t       exp_addr [$];
  data_t       exp_data [$];
  addr_t       keep_addr [$];
  data_t       keep_data [$];
  data_t       lo;
  addr_t       addr;
  cycle_type_t ctype;
  state_t      prev_state;
  logic        first_fetch;
  logic        random_ready;
  int          errors;
  int          test_start;
  int          tests_ok;
  int          tests_bad;
  string       cur_test;

  i8008_top uut (
    .clk   (clk),
    .rst   (rst),
    .d_in  (d_in),
    .ready (ready),
    .d_out (d_out),
    .state (state)
  );

  always #4 clk = ~clk;

  function automatic int unsigned rand_bits(int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic reg_sel_t rand_reg();
    return reg_sel_t'(rand_bits(3) % 7); // A to L, never M
  endfunction

  task automatic check_data(string what, data_t exp, data_t act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %h, got %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_addr(string what, addr_t exp, addr_t act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %h, got %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_state(string what, state_t exp, state_t act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %s, got %s", cur_test, what, exp.name(), act.name());
      errors++;
    end
  endtask

  task automatic emit(data_t b);
    mem[gen_pc] = b;
    gen_pc = gen_pc + 14'd1;
  endtask

  task automatic new_program();
    for (int i = 0; i < 16384; i++) begin
      mem[i] = data_t'(i) ^ data_t'(i >> 8); // Low byte mixed with high bits
    end
    for (int r = 0; r < 7; r++) begin
      model_regs[r] = 8'h00;
    end
    model_c = 1'b0;
    gen_pc  = '0;
    exp_addr.delete();
    exp_data.delete();
  endtask

  task automatic gen_lri(reg_sel_t r, data_t v);
    emit({GRP_IMM, r, SSS_LRI});
    emit(v);
    model_regs[r] = v;
  endtask

  task automatic gen_mov(reg_sel_t d, reg_sel_t s);
    emit({GRP_MOV, d, s});
    model_regs[d] = model_regs[s];
  endtask

  // H and L reloaded so every store has a fresh address
  task automatic gen_store(reg_sel_t r);
    gen_lri(REG_H, data_t'(rand_bits(8)));
    gen_lri(REG_L, data_t'(rand_bits(8)));
    emit({GRP_MOV, REG_M, r});
    exp_addr.push_back({model_regs[REG_H][5:0], model_regs[REG_L]});
    exp_data.push_back(model_regs[r]);
  endtask

  task automatic gen_alu(alu_op_t op, reg_sel_t s);
    int a;
    int b;
    int r;
    a = int'(model_regs[REG_A]);
    b = int'(model_regs[s]);
    emit({GRP_ALU, op, s});
    case (op)
      ADD:     r = a + b;
      ADC:     r = a + b + int'(model_c);
      SBB:     r = a - b - int'(model_c);
      ANA:     r = a & b;
      XRA:     r = a ^ b;
      ORA:     r = a | b;
      default: r = a - b; // SUB and CMP
    endcase
    if (op == ANA || op == XRA || op == ORA) begin
      model_c = 1'b0;
    end else if (op == ADD || op == ADC) begin
      model_c = (r > 255);
    end else begin
      model_c = (r < 0); // Borrow
    end
    if (op != CMP) begin
      model_regs[REG_A] = r[7:0];
    end
  endtask

  task automatic gen_rot(rot_op_t k);
    data_t a;
    a = model_regs[REG_A];
    emit({GRP_IMM, 1'b0, k, SSS_ROT});
    case (k)
      RLC:     model_regs[REG_A] = {a[6:0], a[7]};
      RRC:     model_regs[REG_A] = {a[0], a[7:1]};
      RAL:     model_regs[REG_A] = {a[6:0], model_c};
      default: model_regs[REG_A] = {model_c, a[7:1]};
    endcase
    model_c = (k == RLC || k == RAL) ? a[7] : a[0]; // Bit shifted out
  endtask

  task automatic gen_incdec(reg_sel_t r, logic dec);
    emit({GRP_IMM, r, dec ? SSS_DCR : SSS_INR});
    model_regs[r] = dec ? model_regs[r] - 8'd1 : model_regs[r] + 8'd1;
  endtask

  task automatic gen_random_ops(int n);
    for (int i = 0; i < n; i++) begin
      case (rand_bits(3))
        0, 1:    gen_alu(alu_op_t'(3'(rand_bits(3))), rand_reg());
        2:       gen_rot(rot_op_t'(2'(rand_bits(2))));
        3:       gen_incdec(reg_sel_t'(1 + rand_bits(3) % 6), rand_bits(1) != 0);
        4:       gen_mov(rand_reg(), rand_reg());
        default: gen_store(rand_reg());
      endcase
    end
  endtask

  // Memory model, runs on each falling edge
  task automatic bus_step();
    if (!rst && (prev_state == T2 || prev_state == WAIT)) begin
      check_state("state after T2", ready ? T3 : WAIT, state);
    end
    case (state)
      T1: lo = d_out;
      T2: begin
        ctype = cycle_type_t'(d_out[7:6]);
        addr  = {d_out[5:0], lo};
        if (first_fetch) begin
          check_data("first T2 byte", 8'h00, d_out); // PCI at address 0
          first_fetch = 1'b0;
        end
        if (ctype != PCW) begin
          check_addr("read address", next_pc, addr);
          next_pc = next_pc + 14'd1;
        end
      end
      T3: begin
        if (ctype != PCW) begin
          d_in = mem[addr];
        end else if (exp_addr.size() == 0) begin
          $display("Unexpected memory write in %s", cur_test);
          errors++;
        end else begin
          check_addr("store address", exp_addr.pop_front(), addr);
          check_data("store data", exp_data.pop_front(), d_out);
        end
      end
      default: ;
    endcase
    prev_state = state;
    ready = random_ready ? (rand_bits(1) != 0) : 1'b1;
  endtask

  task automatic cycle();
    @(negedge clk);
    bus_step();
  endtask

  task automatic run_program(string name);
    int waited;
    cur_test   = name;
    test_start = errors;
    rst = 1'b1;
    repeat (5) cycle();
    next_pc     = '0;
    first_fetch = 1'b1;
    rst = 1'b0;
    waited = 0;
    while (state != STOPPED && waited < 20000) begin
      cycle();
      waited++;
    end
    if (state != STOPPED) begin
      $display("Timeout in %s, core never reached STOPPED", name);
      errors++;
    end
    check_addr("bytes read", gen_pc, next_pc);
    if (exp_addr.size() != 0) begin
      $display("%s ended with %0d expected stores missing", name, exp_addr.size());
      errors++;
    end
  endtask

  task automatic finish_test();
    if (errors == test_start) begin
      $display("test %s: ok", cur_test);
      tests_ok++;
    end else begin
      $display("test %s: %0d errors", cur_test, errors - test_start);
      tests_bad++;
    end
  endtask

  initial begin
    rst          = 1'b1;
    ready        = 1'b1;
    d_in         = 8'h00;
    random_ready = 1'b0;
    prev_state   = T1;
    errors       = 0;
    tests_ok     = 0;
    tests_bad    = 0;

    new_program();
    for (int i = 0; i < 16; i++) begin
      gen_mov(rand_reg(), rand_reg());
    end
    emit(OP_HLT);
    run_program("fetch");
    finish_test();

    new_program();
    for (int r = 0; r < 7; r++) begin
      gen_lri(reg_sel_t'(r), data_t'(rand_bits(8)));
    end
    for (int r = 0; r < 7; r++) begin
      gen_store(reg_sel_t'(r));
    end
    emit(OP_HLT);
    run_program("store");
    finish_test();

    new_program();
    for (int r = 0; r < 7; r++) begin
      gen_lri(reg_sel_t'(r), data_t'(rand_bits(8)));
    end
    gen_random_ops(150);
    gen_store(REG_A);
    emit(OP_HLT);
    keep_addr = exp_addr;
    keep_data = exp_data;
    run_program("alu");
    finish_test();

    // Same program again, with back-pressure
    exp_addr     = keep_addr;
    exp_data     = keep_data;
    random_ready = 1'b1;
    run_program("wait");
    finish_test();
    random_ready = 1'b0;

    new_program();
    gen_lri(REG_A, data_t'(rand_bits(8)));
    emit(OP_HLT);
    run_program("halt");
    repeat (50) begin
      cycle();
      check_state("halt hold", STOPPED, state);
    end
    finish_test();

    $display("summary: %0d tests ok, %0d tests failing", tests_ok, tests_bad);
    if (tests_bad == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- i8008_top.f
hdl/i8008_pkg.sv
hdl/i8008_ctrl_if.sv
hdl/i8008_reg_file.sv
hdl/i8008_alu.sv
hdl/i8008_datapath.sv
hdl/i8008_ctrl.sv
hdl/i8008_top.sv
sim/i8008_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= i8008_tb
FILELIST  ?= i8008_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TESTS PASSED'

clean:
	rm -rf $(OBJ_DIR)
